//--- design/rv_pkg.sv
// RV32I core shared definitions
// ISA encodings, instruction formats, control and retire records
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] BASE_ADDR = 32'h0100_0000;

  // Instruction memory geometry, indexed by PC[9:2]
  localparam int IMEM_WORDS = 256;
  localparam int IMEM_AW    = 8;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  // Only decoded for its immediate; the core does not execute stores
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic {
    WB_ALU = 1'b0,
    WB_PC4 = 1'b1
  } wb_sel_e;

  // Instruction format views, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_u;

  typedef struct packed {
    logic    reg_we;
    logic    op_a_pc;
    logic    op_b_imm;
    alu_op_e alu_op;
    wb_sel_e wb_sel;
    logic    is_branch;
    logic    is_jal;
    logic    is_jalr;
    logic    pc_en;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } retire_t;

endpackage : rv_pkg

`default_nettype wire

//--- design/fetch.sv
// Fetch unit
// Holds the PC and picks the next one from jump, branch or sequential flow
`timescale 1ns/1ps
`default_nettype none

module fetch (
  input  logic                    clk,
  input  logic                    rst_i,
  input  rv_pkg::ctrl_t           ctrl_i,
  input  logic                    br_taken_i,
  input  logic [rv_pkg::XLEN-1:0] imm_i,
  input  logic [rv_pkg::XLEN-1:0] alu_res_i,
  output logic [rv_pkg::XLEN-1:0] pc_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;

  // JALR first, then PC-relative jumps and taken branches
  always_comb begin
    if (ctrl_i.is_jalr) begin
      pc_next = {alu_res_i[XLEN-1:2], 2'b00};
    end else if (ctrl_i.is_jal || (ctrl_i.is_branch && br_taken_i)) begin
      pc_next = pc_q + imm_i;
    end else begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= BASE_ADDR;
    end else if (ctrl_i.pc_en) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // Every target reaching the PC register must stay word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i) pc_q[1:0] == 2'b00)
    else $error("fetch: PC %h is not word aligned", pc_q);

endmodule : fetch

`default_nettype wire

//--- design/imem.sv
// Instruction memory
// Word array with a program load port and a combinational fetch read
`timescale 1ns/1ps
`default_nettype none

module imem (
  input  logic                       clk,
  input  logic                       prog_we_i,
  input  logic [rv_pkg::IMEM_AW-1:0] prog_addr_i,
  input  logic [rv_pkg::XLEN-1:0]    prog_data_i,
  input  logic [rv_pkg::XLEN-1:0]    pc_i,
  output logic [rv_pkg::XLEN-1:0]    insn_o
);
  import rv_pkg::*;

  logic [XLEN-1:0]    mem [IMEM_WORDS];
  logic [IMEM_AW-1:0] rd_idx;

  // Power-up contents are zero, which decodes as a no-op
  initial begin
    for (int i = 0; i < IMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (prog_we_i) begin
      mem[prog_addr_i] <= prog_data_i;
    end
  end

  // Upper PC bits are ignored, so fetch wraps inside the array
  assign rd_idx = pc_i[IMEM_AW+1:2];
  assign insn_o = mem[rd_idx];

endmodule : imem

`default_nettype wire

//--- design/decode.sv
// Instruction decoder
// Extracts register and function fields and forms the sign-extended immediate
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  logic [rv_pkg::XLEN-1:0] insn_i,
  output logic [6:0]              opcode_o,
  output logic [4:0]              rd_o,
  output logic [4:0]              rs1_o,
  output logic [4:0]              rs2_o,
  output logic [2:0]              funct3_o,
  output logic [6:0]              funct7_o,
  output logic [rv_pkg::XLEN-1:0] imm_o
);
  import rv_pkg::*;

  insn_u insn;

  assign insn = insn_i;

  // Register and function fields sit at the same place in every format
  assign opcode_o = insn.r_fmt.opcode;
  assign rd_o     = insn.r_fmt.rd;
  assign rs1_o    = insn.r_fmt.rs1;
  assign rs2_o    = insn.r_fmt.rs2;
  assign funct3_o = insn.r_fmt.funct3;
  assign funct7_o = insn.r_fmt.funct7;

  always_comb begin
    case (insn.r_fmt.opcode)
      OPC_OP_IMM, OPC_JALR: begin
        // Shift amounts come out of the low five bits
        imm_o = {{20{insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
      end
      OPC_STORE: begin
        imm_o = {{20{insn.s_fmt.imm_11_5[6]}}, insn.s_fmt.imm_11_5, insn.s_fmt.imm_4_0};
      end
      OPC_BRANCH: begin
        imm_o = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                 insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
      end
      OPC_LUI, OPC_AUIPC: begin
        imm_o = {insn.u_fmt.imm_31_12, 12'b0};
      end
      OPC_JAL: begin
        imm_o = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                 insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule : decode

`default_nettype wire

//--- design/control.sv
// Control unit
// Maps opcode and function fields onto datapath selects, holds the core during load
`timescale 1ns/1ps
`default_nettype none

module control (
  input  logic          rst_i,
  input  logic          prog_we_i,
  input  logic [6:0]    opcode_i,
  input  logic [2:0]    funct3_i,
  input  logic [6:0]    funct7_i,
  output rv_pkg::ctrl_t ctrl_o
);
  import rv_pkg::*;

  logic    hold;
  alu_op_e arith_op;
  ctrl_t   ctrl;

  assign hold = rst_i || prog_we_i;

  // Shared funct3 mapping for OP and OP-IMM; funct7[5] picks SRA/SRAI
  always_comb begin
    case (funct3_i)
      3'b000:  arith_op = ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7_i[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.wb_sel = WB_ALU;
    ctrl.pc_en  = 1'b1;
    case (opcode_i)
      OPC_OP: begin
        ctrl.reg_we = 1'b1;
        // SUB only exists in the register form
        ctrl.alu_op = (funct3_i == 3'b000 && funct7_i[5]) ? ALU_SUB : arith_op;
      end
      OPC_OP_IMM: begin
        ctrl.reg_we   = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.alu_op   = arith_op;
      end
      OPC_LUI: begin
        ctrl.reg_we   = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.alu_op   = ALU_PASS_B;
      end
      OPC_AUIPC, OPC_JAL: begin
        ctrl.reg_we   = 1'b1;
        ctrl.op_a_pc  = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.wb_sel   = (opcode_i == OPC_JAL) ? WB_PC4 : WB_ALU;
        ctrl.is_jal   = (opcode_i == OPC_JAL);
      end
      OPC_JALR: begin
        // Target is rs1 + imm, formed by the ALU
        ctrl.reg_we   = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.wb_sel   = WB_PC4;
        ctrl.is_jalr  = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
      end
      default: begin
        // Anything else retires as a no-op
      end
    endcase
    if (hold) begin
      ctrl.reg_we = 1'b0;
      ctrl.pc_en  = 1'b0;
    end
  end

  assign ctrl_o = ctrl;

  // Branches never write back
  a_branch_no_wb: assert property (@(opcode_i) !(ctrl_o.reg_we && ctrl_o.is_branch))
    else $error("control: branch with register write enabled");

endmodule : control

`default_nettype wire

//--- design/register_file.sv
// Integer register file
// 31 writable registers, x0 reads as zero, two async reads, one sync write
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic [4:0]              rs1_i,
  input  logic [4:0]              rs2_i,
  input  logic [4:0]              rd_i,
  input  logic                    we_i,
  input  logic [rv_pkg::XLEN-1:0] wdata_i,
  output logic [rv_pkg::XLEN-1:0] rs1_data_o,
  output logic [rv_pkg::XLEN-1:0] rs2_data_o
);
  import rv_pkg::*;

  // x0 has a slot but the write port never reaches it
  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

  // Dropped x0 writes keep both ports at zero
  a_x0_zero: assert property (@(posedge clk) disable iff (rst_i)
    ((rs1_i == 5'd0) |-> (rs1_data_o == '0)) and ((rs2_i == 5'd0) |-> (rs2_data_o == '0)))
    else $error("register_file: x0 read back non-zero");

endmodule : register_file

`default_nettype wire

//--- design/alu.sv
// Integer ALU
// Arithmetic, logic and shift results plus the branch condition
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [rv_pkg::XLEN-1:0] op_a_i,
  input  logic [rv_pkg::XLEN-1:0] op_b_i,
  input  rv_pkg::alu_op_e         alu_op_i,
  input  logic [2:0]              funct3_i,
  input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
  output logic [rv_pkg::XLEN-1:0] res_o,
  output logic                    br_taken_o
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = op_b_i[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    res_o = op_a_i + op_b_i;
      ALU_SUB:    res_o = op_a_i - op_b_i;
      ALU_SLL:    res_o = op_a_i << shamt;
      ALU_SLT:    res_o = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
      ALU_SLTU:   res_o = {{(XLEN-1){1'b0}}, op_a_i < op_b_i};
      ALU_XOR:    res_o = op_a_i ^ op_b_i;
      ALU_SRL:    res_o = op_a_i >> shamt;
      ALU_SRA:    res_o = $unsigned($signed(op_a_i) >>> shamt);
      ALU_OR:     res_o = op_a_i | op_b_i;
      ALU_AND:    res_o = op_a_i & op_b_i;
      ALU_PASS_B: res_o = op_b_i;
      default:    res_o = '0;
    endcase
  end

  // Branch compare always works on the raw register values
  assign eq  = (rs1_data_i == rs2_data_i);
  assign lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign ltu = (rs1_data_i < rs2_data_i);

  always_comb begin
    case (funct3_i)
      3'b000:  br_taken_o = eq;
      3'b001:  br_taken_o = !eq;
      3'b100:  br_taken_o = lt;
      3'b101:  br_taken_o = !lt;
      3'b110:  br_taken_o = ltu;
      3'b111:  br_taken_o = !ltu;
      default: br_taken_o = 1'b0;
    endcase
  end

endmodule : alu

`default_nettype wire

//--- design/pd3.sv
// Single-cycle RV32I core top level
// Connects fetch, decode, control, registers and ALU, reports each retired instruction
`timescale 1ns/1ps
`default_nettype none

module pd3 (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       prog_we_i,
  input  logic [rv_pkg::IMEM_AW-1:0] prog_addr_i,
  input  logic [rv_pkg::XLEN-1:0]    prog_data_i,
  output rv_pkg::retire_t            retire_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] insn;
  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm;
  ctrl_t           ctrl;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic            br_taken;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] wb_data;

  fetch fetch_stage (
    .clk        (clk),
    .rst_i      (rst_i),
    .ctrl_i     (ctrl),
    .br_taken_i (br_taken),
    .imm_i      (imm),
    .alu_res_i  (alu_res),
    .pc_o       (pc)
  );

  imem imem_unit (
    .clk         (clk),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .pc_i        (pc),
    .insn_o      (insn)
  );

  decode decode_stage (
    .insn_i   (insn),
    .opcode_o (opcode),
    .rd_o     (rd),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .funct3_o (funct3),
    .funct7_o (funct7),
    .imm_o    (imm)
  );

  control control_unit (
    .rst_i     (rst_i),
    .prog_we_i (prog_we_i),
    .opcode_i  (opcode),
    .funct3_i  (funct3),
    .funct7_i  (funct7),
    .ctrl_o    (ctrl)
  );

  register_file reg_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rd),
    .we_i       (ctrl.reg_we),
    .wdata_i    (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // Operand selects
  assign op_a = ctrl.op_a_pc  ? pc  : rs1_data;
  assign op_b = ctrl.op_b_imm ? imm : rs2_data;

  alu alu_stage (
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .alu_op_i   (ctrl.alu_op),
    .funct3_i   (funct3),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .res_o      (alu_res),
    .br_taken_o (br_taken)
  );

  // Jumps link pc+4, everything else writes the ALU result
  assign pc_plus4 = pc + 32'd4;
  assign wb_data  = (ctrl.wb_sel == WB_PC4) ? pc_plus4 : alu_res;

  // Retire record for the instruction committing at the next edge
  assign retire_o.valid = ctrl.pc_en;
  assign retire_o.pc    = pc;
  assign retire_o.rd    = ctrl.reg_we ? rd : 5'd0;
  assign retire_o.data  = wb_data;

endmodule : pd3

`default_nettype wire

//--- tb/tb_iss.svh
// Reference model of the RV32I subset and random program generator
// Mirrors register file and PC, and draws legal encodings from an LFSR
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

logic [31:0] lfsr_state = 32'he50d;
logic [31:0] xreg [32];
logic [31:0] model_pc;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_next();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_next()};
  end
  return r;
endfunction

// Nonzero multiple of 4 in -64..60, so no jump lands on itself
function automatic logic [31:0] jump_offset();
  logic [31:0] r;
  logic [4:0]  k;
  r = take_bits(5);
  k = r[4:0];
  if (k == 5'd0) begin
    k = 5'd1;
  end
  return {{25{k[4]}}, k, 2'b00};
endfunction

function automatic logic [31:0] make_insn();
  logic [31:0] r;
  logic [31:0] off;
  logic [5:0]  kind;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [6:0]  opc;
  logic [6:0]  f7;
  logic [11:0] imm12;
  r    = take_bits(24);
  kind = r[5:0];
  rd   = r[10:6];
  rs1  = r[15:11];
  rs2  = r[20:16];
  f3   = r[23:21];
  if (kind < 6'd3) begin
    // LOAD, STORE, FENCE or SYSTEM, none of them executed
    r = take_bits(27);
    case (r[26:25])
      2'd0:    opc = 7'b0000011;
      2'd1:    opc = 7'b0100011;
      2'd2:    opc = 7'b0001111;
      default: opc = 7'b1110011;
    endcase
    return {r[24:0], opc};
  end else if (kind < 6'd18) begin
    r  = take_bits(1);
    // Only SUB and SRA use funct7
    f7 = (r[0] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  end else if (kind < 6'd36) begin
    r     = take_bits(12);
    imm12 = r[11:0];
    if (f3 == 3'b001) begin
      imm12[11:5] = 7'h00;
    end else if (f3 == 3'b101) begin
      imm12[11:5] = {1'b0, imm12[10], 5'b00000};
    end
    return {imm12, rs1, f3, rd, OPC_OP_IMM};
  end else if (kind < 6'd44) begin
    r   = take_bits(20);
    opc = (kind < 6'd40) ? OPC_LUI : OPC_AUIPC;
    return {r[19:0], rd, opc};
  end else if (kind < 6'd54) begin
    // funct3 010 and 011 are not branches
    if (f3[2:1] == 2'b01) begin
      f3[2] = 1'b1;
    end
    off = jump_offset();
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  end else if (kind < 6'd59) begin
    off = jump_offset();
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  end else begin
    // Target offset inside the 1 KiB window, low bits left random
    r     = take_bits(10);
    imm12 = {2'b00, r[9:0]};
    return {imm12, 5'd0, 3'b000, rd, OPC_JALR};
  end
endfunction

function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
                                             input logic is_reg, input logic [31:0] a,
                                             input logic [31:0] b);
  logic [31:0] res;
  case (f3)
    3'b000:  res = (is_reg && alt) ? a - b : a + b;
    3'b001:  res = a << b[4:0];
    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  res = (a < b) ? 32'd1 : 32'd0;
    3'b100:  res = a ^ b;
    3'b110:  res = a | b;
    3'b111:  res = a & b;
    default: begin
      if (alt) begin
        res = $signed(a) >>> b[4:0];
      end else begin
        res = a >> b[4:0];
      end
    end
  endcase
  return res;
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

task automatic reset_model();
  for (int i = 0; i < 32; i++) begin
    xreg[i] = '0;
  end
  model_pc = BASE_ADDR;
endtask

// Executes the instruction at model_pc, returns rd (0 if no write) and its data
task automatic model_step(output logic [4:0] exp_rd, output logic [31:0] exp_data);
  logic [31:0] insn;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;
  logic [31:0] res;
  logic [31:0] next_pc;
  logic        we;
  insn    = image[model_pc[9:2]];
  a       = xreg[insn[19:15]];
  b       = xreg[insn[24:20]];
  imm_i   = {{20{insn[31]}}, insn[31:20]};
  imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  imm_u   = {insn[31:12], 12'h000};
  we      = 1'b0;
  res     = '0;
  next_pc = model_pc + 32'd4;
  case (insn[6:0])
    OPC_OP: begin
      we  = 1'b1;
      res = arith_result(insn[14:12], insn[30], 1'b1, a, b);
    end
    OPC_OP_IMM: begin
      we  = 1'b1;
      res = arith_result(insn[14:12], insn[30], 1'b0, a, imm_i);
    end
    OPC_LUI: begin
      we  = 1'b1;
      res = imm_u;
    end
    OPC_AUIPC: begin
      we  = 1'b1;
      res = model_pc + imm_u;
    end
    OPC_JAL: begin
      we      = 1'b1;
      res     = model_pc + 32'd4;
      next_pc = model_pc + imm_j;
    end
    OPC_JALR: begin
      we      = 1'b1;
      res     = model_pc + 32'd4;
      next_pc = (a + imm_i) & ~32'd3;
    end
    OPC_BRANCH: begin
      if (branch_cond(insn[14:12], a, b)) begin
        next_pc = model_pc + imm_b;
      end
    end
    default: begin
    end
  endcase
  exp_rd   = we ? insn[11:7] : 5'd0;
  exp_data = res;
  if (exp_rd != 5'd0) begin
    xreg[exp_rd] = res;
  end
  model_pc = next_pc;
endtask

`endif

//--- tb/tb_pd3.sv
// Testbench for the single-cycle RV32I core
// Loads a random program, runs it and checks every retirement against a model
`timescale 1ns/1ps
`default_nettype none

module tb_pd3;
  import rv_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 2;
  localparam int RUN_CYCLES    = 2000;
  localparam int WATCHDOG_TIME = (IMEM_WORDS + RUN_CYCLES + 100) * CLK_PERIOD;

  logic               clk;
  logic               rst;
  logic               prog_we;
  logic [IMEM_AW-1:0] prog_addr;
  logic [XLEN-1:0]    prog_data;
  retire_t            retire;

  // Program image shared by the loader and the model
  logic [XLEN-1:0] image [IMEM_WORDS];

  `include "tb_iss.svh"

  pd3 u_dut (
    .clk         (clk),
    .rst_i       (rst),
    .prog_we_i   (prog_we),
    .prog_addr_i (prog_addr),
    .prog_data_i (prog_data),
    .retire_o    (retire)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: t=%0t %s: expected %h, got %h", $time, what, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_TIME);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      image[i] = make_insn();
    end
    reset_model();

    // Load one word per cycle, reset overlaps the first words
    for (int i = 0; i < IMEM_WORDS; i++) begin
      prog_we   = 1'b1;
      prog_addr = i[IMEM_AW-1:0];
      prog_data = image[i];
      if (i == RESET_CYCLES) begin
        rst = 1'b0;
      end
      if (i > 0) begin
        #1;
        check_value("retire valid while held", 32'd0, retire.valid);
        check_value("pc while held", BASE_ADDR, retire.pc);
      end
      @(negedge clk);
    end
    prog_we = 1'b0;

    // Retire port is combinational from the PC, sampled mid low phase
    for (int n = 0; n < RUN_CYCLES; n++) begin
      #1;
      check_value("retire valid", 32'd1, retire.valid);
      check_value("retire pc", model_pc, retire.pc);
      model_step(exp_rd, exp_data);
      check_value("retire rd", exp_rd, retire.rd);
      if (exp_rd != 5'd0) begin
        check_value("retire data", exp_data, retire.data);
      end
      @(negedge clk);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule : tb_pd3

`default_nettype wire

//--- files.f
+incdir+tb
design/rv_pkg.sv
design/fetch.sv
design/imem.sv
design/decode.sv
design/control.sv
design/register_file.sv
design/alu.sv
design/pd3.sv
tb/tb_pd3.sv

//--- Bender.yml
package:
  name: pd3

sources:
  - files:
      - design/rv_pkg.sv
      - design/fetch.sv
      - design/imem.sv
      - design/decode.sv
      - design/control.sv
      - design/register_file.sv
      - design/alu.sv
      - design/pd3.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_pd3.sv
